/* compile.f */
+incdir+hdl
hdl/tracker_pkg.sv
hdl/pix_if.sv
hdl/pixel_decode.sv
hdl/mask_execute.sv
hdl/com_divider.sv
hdl/com_result.sv
hdl/color_tracker.sv
test/tracker_checker.sv
test/tb_color_tracker.sv

/* hdl/color_tracker.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module color_tracker import tracker_pkg::*; (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    // camera pixel stream
    input  logic                 pix_valid_i,
    output logic                 pix_ready_o,
    input  logic [15:0]          pix_data_i,   // rgb565
    input  logic [`HCOUNT_W-1:0] pix_hcount_i,
    input  logic [`VCOUNT_W-1:0] pix_vcount_i,
    input  logic                 pix_last_i,
    // control
    input  channel_e             channel_i,
    input  logic [`CHAN_W-1:0]   lower_i,
    input  logic [`CHAN_W-1:0]   upper_i,
    input  display_e             display_i,
    input  logic                 crosshair_i,
    // display pixel stream
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output rgb_t                 out_rgb_o,
    output logic                 out_mask_o,
    // centre of mass
    output logic                 com_valid_o,
    output logic [`HCOUNT_W-1:0] com_x_o,
    output logic [`VCOUNT_W-1:0] com_y_o
);

    pix_if decode_to_exec ();  // converted pixel
    pix_if exec_to_result ();  // pixel with picked byte and mask

    pixel_decode i_decode (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .in_valid_i   (pix_valid_i),
        .in_ready_o   (pix_ready_o),
        .in_data_i    (pix_data_i),
        .in_hcount_i  (pix_hcount_i),
        .in_vcount_i  (pix_vcount_i),
        .in_last_i    (pix_last_i),
        .dec_o        (decode_to_exec.src)
    );

    mask_execute i_execute (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .channel_i    (channel_i),
        .lower_i      (lower_i),
        .upper_i      (upper_i),
        .dec_i        (decode_to_exec.dst),
        .exe_o        (exec_to_result.src)
    );

    com_result i_result (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .display_i    (display_i),
        .crosshair_i  (crosshair_i),
        .exe_i        (exec_to_result.dst),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_rgb_o    (out_rgb_o),
        .out_mask_o   (out_mask_o),
        .com_valid_o  (com_valid_o),
        .com_x_o      (com_x_o),
        .com_y_o      (com_y_o)
    );

endmodule

/* hdl/com_divider.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module com_divider import tracker_pkg::*; (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    input  logic                 start_i,
    input  logic [`SUM_W-1:0]    sum_x_i,
    input  logic [`SUM_W-1:0]    sum_y_i,
    input  logic [`CNT_W-1:0]    count_i,   // never zero on a start
    output logic                 busy_o,
    output logic                 done_o,
    output logic [`HCOUNT_W-1:0] mean_x_o,  // held until the next done
    output logic [`VCOUNT_W-1:0] mean_y_o
);

    localparam int STEP_W = $clog2(`SUM_W);

    div_state_e               state;
    logic [STEP_W-1:0]        step;         // quotient bit being produced
    logic [`CNT_W-1:0]        den;
    logic [`CNT_W:0]          rem_x, rem_y;
    logic [`SUM_W-1:0]        quo_x, quo_y; // dividend shifts out as the quotient shifts in
    logic [`CNT_W+`SUM_W:0]   nxt_x, nxt_y; // {rem, quo} after one step

    // one restoring step shifts in the next dividend bit and subtracts if it fits
    function automatic logic [`CNT_W+`SUM_W:0] div_step(
        input logic [`CNT_W:0]   rem,
        input logic [`SUM_W-1:0] quo,
        input logic [`CNT_W-1:0] den_v
    );
        logic [`CNT_W+1:0] trial;
        logic              fits;
        trial = {rem, quo[`SUM_W-1]};
        fits  = trial >= {2'b00, den_v};
        if (fits) begin
            trial = trial - {2'b00, den_v}; // result is below den so the top bit drops
        end
        return {trial[`CNT_W:0], quo[`SUM_W-2:0], fits};
    endfunction

    always_comb begin
        nxt_x = div_step(rem_x, quo_x, den); // both run in lockstep
        nxt_y = div_step(rem_y, quo_y, den);
    end

    assign busy_o = state != DIV_IDLE;
    assign done_o = state == DIV_DONE;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state    <= DIV_IDLE;
            step     <= '0;
            mean_x_o <= '0;
            mean_y_o <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    step <= '0;
                    if (start_i) state <= DIV_RUN;
                end
                DIV_RUN: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(`SUM_W - 1)) begin
                        state    <= DIV_DONE;
                        mean_x_o <= nxt_x[`HCOUNT_W-1:0]; // mean never exceeds a coordinate
                        mean_y_o <= nxt_y[`VCOUNT_W-1:0];
                    end
                end
                default: state <= DIV_IDLE; // DIV_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (state == DIV_IDLE && start_i) begin
            den   <= count_i;
            rem_x <= '0;
            rem_y <= '0;
            quo_x <= sum_x_i;
            quo_y <= sum_y_i;
        end else if (state == DIV_RUN) begin
            rem_x <= nxt_x[`CNT_W+`SUM_W:`SUM_W];
            quo_x <= nxt_x[`SUM_W-1:0];
            rem_y <= nxt_y[`CNT_W+`SUM_W:`SUM_W];
            quo_y <= nxt_y[`SUM_W-1:0];
        end
    end

    // the result stage must hold off a new frame end while we run
    a_no_start_busy: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        start_i |-> !busy_o);

    // sums of coordinates over their count give a quotient that fits a coordinate
    a_mean_fits: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        state == DIV_RUN && step == STEP_W'(`SUM_W - 1)
            |-> nxt_x[`SUM_W-1:`HCOUNT_W] == '0 && nxt_y[`SUM_W-1:`VCOUNT_W] == '0);

endmodule

/* hdl/com_result.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module com_result import tracker_pkg::*; (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    input  display_e             display_i,
    input  logic                 crosshair_i,
    pix_if.dst                   exe_i,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output rgb_t                 out_rgb_o,
    output logic                 out_mask_o,
    output logic                 com_valid_o,  // one cycle per finished division
    output logic [`HCOUNT_W-1:0] com_x_o,      // centre held from the last frame
    output logic [`VCOUNT_W-1:0] com_y_o
);

    logic              take;      // transfer from execute this edge
    logic              div_busy;
    logic              div_start;
    logic [`SUM_W-1:0] sum_x, sum_y;
    logic [`SUM_W-1:0] sum_x_nxt, sum_y_nxt;
    logic [`CNT_W-1:0] cnt, cnt_nxt;
    logic              on_cross;  // pixel lies on the held row or column
    rgb_t              mode_rgb;
    rgb_t              pix_rgb;   // after the crosshair override

    // frame end waits while the previous division still runs
    assign exe_i.ready = (!out_valid_o || out_ready_i) && !(exe_i.last && div_busy);
    assign take        = exe_i.valid && exe_i.ready;

    // running totals including the pixel now on the input
    always_comb begin
        sum_x_nxt = sum_x;
        sum_y_nxt = sum_y;
        cnt_nxt   = cnt;
        if (exe_i.mask) begin
            sum_x_nxt = sum_x + {{(`SUM_W - `HCOUNT_W){1'b0}}, exe_i.hcount};
            sum_y_nxt = sum_y + {{(`SUM_W - `VCOUNT_W){1'b0}}, exe_i.vcount};
            cnt_nxt   = cnt + 1'b1;
        end
    end

    assign div_start = take && exe_i.last && (cnt_nxt != '0); // empty frame keeps old centre

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x <= '0;
            sum_y <= '0;
            cnt   <= '0;
        end else if (take) begin
            if (exe_i.last) begin // divider latches the totals, restart for next frame
                sum_x <= '0;
                sum_y <= '0;
                cnt   <= '0;
            end else begin
                sum_x <= sum_x_nxt;
                sum_y <= sum_y_nxt;
                cnt   <= cnt_nxt;
            end
        end
    end

    com_divider i_divider (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .start_i      (div_start),
        .sum_x_i      (sum_x_nxt),
        .sum_y_i      (sum_y_nxt),
        .count_i      (cnt_nxt),
        .busy_o       (div_busy),
        .done_o       (com_valid_o),
        .mean_x_o     (com_x_o),
        .mean_y_o     (com_y_o)
    );

    always_comb begin
        case (display_i)
            DISP_CHANNEL: mode_rgb = '{exe_i.chan, exe_i.chan, exe_i.chan}; // grey
            DISP_MASK:    mode_rgb = exe_i.mask ? '{'1, '1, '1} : '{'0, '0, '0};
            DISP_OVERLAY: mode_rgb = exe_i.mask ? '{'1, '0, '1} : exe_i.rgb;
            default:      mode_rgb = exe_i.rgb; // DISP_CAMERA
        endcase
    end

    assign on_cross = (exe_i.hcount == com_x_o) || (exe_i.vcount == com_y_o);
    assign pix_rgb  = (crosshair_i && on_cross) ? '{'1, '1, '1} : mode_rgb;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            out_valid_o <= 1'b0;
        end else if (!out_valid_o || out_ready_i) begin
            out_valid_o <= take;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (take) begin
            out_rgb_o  <= pix_rgb;
            out_mask_o <= exe_i.mask;
        end
    end

endmodule

/* hdl/mask_execute.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module mask_execute import tracker_pkg::*; (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  channel_e           channel_i,
    input  logic [`CHAN_W-1:0] lower_i,  // inclusive bounds
    input  logic [`CHAN_W-1:0] upper_i,
    pix_if.dst                 dec_i,
    pix_if.src                 exe_o
);

    logic [`CHAN_W-1:0] pick;   // byte under test
    logic               in_box; // lower <= pick <= upper

    always_comb begin
        case (channel_i)
            CH_CR:   pick = dec_i.ycc.cr;
            CH_CB:   pick = dec_i.ycc.cb;
            default: pick = dec_i.ycc.y; // CH_Y
        endcase
    end

    assign in_box      = (pick >= lower_i) && (pick <= upper_i);
    assign dec_i.ready = !exe_o.valid || exe_o.ready;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            exe_o.valid <= 1'b0;
        end else if (dec_i.ready) begin
            exe_o.valid <= dec_i.valid;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (dec_i.valid && dec_i.ready) begin
            exe_o.hcount <= dec_i.hcount;
            exe_o.vcount <= dec_i.vcount;
            exe_o.last   <= dec_i.last;
            exe_o.rgb    <= dec_i.rgb;
            exe_o.ycc    <= dec_i.ycc;
            exe_o.chan   <= pick;   // carried so the display needs no reselect
            exe_o.mask   <= in_box;
        end
    end

endmodule

/* hdl/pix_if.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

// one pixel record between two pipeline stages, valid/ready handshake
interface pix_if import tracker_pkg::*; ();

    logic                 valid;  // record present on this hop
    logic                 ready;  // receiver takes it this edge
    logic [`HCOUNT_W-1:0] hcount;
    logic [`VCOUNT_W-1:0] vcount;
    logic                 last;   // final pixel of the frame
    rgb_t                 rgb;    // expanded camera pixel
    ycc_t                 ycc;    // converted pixel
    logic [`CHAN_W-1:0]   chan;   // byte picked by the channel select
    logic                 mask;   // threshold result, second hop only

    // sending stage
    modport src (
        output valid, hcount, vcount, last, rgb, ycc, chan, mask,
        input  ready
    );

    // receiving stage
    modport dst (
        input  valid, hcount, vcount, last, rgb, ycc, chan, mask,
        output ready
    );

endinterface

/* hdl/pixel_decode.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module pixel_decode import tracker_pkg::*; (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  logic [15:0]          in_data_i,   // rgb565
    input  logic [`HCOUNT_W-1:0] in_hcount_i,
    input  logic [`VCOUNT_W-1:0] in_vcount_i,
    input  logic                 in_last_i,
    pix_if.src                   dec_o
);

    rgb_t rgb_in; // zero-filled rgb888
    int   y_acc;  // full precision results before truncation
    int   cr_acc;
    int   cb_acc;

    assign rgb_in = '{r: {in_data_i[15:11], 3'b000},
                      g: {in_data_i[10:5], 2'b00},
                      b: {in_data_i[4:0], 3'b000}};

    // weighted sums, +128 rounds, arithmetic shift floors the negatives
    always_comb begin
        y_acc  = ((`Y_R * int'(rgb_in.r) + `Y_G * int'(rgb_in.g) + `Y_B * int'(rgb_in.b)
                  + 128) >>> 8) + `Y_OFS;
        cb_acc = ((`CB_R * int'(rgb_in.r) + `CB_G * int'(rgb_in.g) + `CB_B * int'(rgb_in.b)
                  + 128) >>> 8) + `C_OFS;
        cr_acc = ((`CR_R * int'(rgb_in.r) + `CR_G * int'(rgb_in.g) + `CR_B * int'(rgb_in.b)
                  + 128) >>> 8) + `C_OFS;
    end

    assign in_ready_o = !dec_o.valid || dec_o.ready; // empty or draining

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            dec_o.valid <= 1'b0;
        end else if (in_ready_o) begin
            dec_o.valid <= in_valid_i;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk_pixel) begin
        if (in_valid_i && in_ready_o) begin
            dec_o.hcount <= in_hcount_i;
            dec_o.vcount <= in_vcount_i;
            dec_o.last   <= in_last_i;
            dec_o.rgb    <= rgb_in;
            dec_o.ycc    <= '{y: y_acc[`CHAN_W-1:0], cr: cr_acc[`CHAN_W-1:0],
                              cb: cb_acc[`CHAN_W-1:0]};
        end
    end

    assign dec_o.chan = '0;   // picked later in execute
    assign dec_o.mask = 1'b0; // no threshold yet on this hop

    // a stalled record must hold until the execute stage takes it
    a_dec_stall_stable: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        dec_o.valid && !dec_o.ready |=> dec_o.valid
            && $stable({dec_o.hcount, dec_o.vcount, dec_o.last, dec_o.rgb, dec_o.ycc}));

endmodule

/* hdl/tracker_consts.svh */
`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// field widths
`define HCOUNT_W 11 // horizontal pixel coordinate
`define VCOUNT_W 10 // vertical pixel coordinate
`define CHAN_W   8  // one colour byte
`define SUM_W    32 // coordinate sums over a frame
`define CNT_W    22 // masked pixel count

// bt.601 integer weights, scaled by 256
`define Y_R  66
`define Y_G  129
`define Y_B  25
`define CB_R (-38)
`define CB_G (-74)
`define CB_B 112
`define CR_R 112
`define CR_G (-94)
`define CR_B (-18)

// offsets added after the >>8
`define Y_OFS 16
`define C_OFS 128

`endif

/* hdl/tracker_pkg.sv */
`include "tracker_consts.svh"

package tracker_pkg;

    // byte that the threshold looks at
    typedef enum logic [1:0] {
        CH_Y  = 2'd0,
        CH_CR = 2'd1,
        CH_CB = 2'd2
    } channel_e;

    typedef enum logic [1:0] {
        DISP_CAMERA  = 2'd0, // plain camera pixel
        DISP_CHANNEL = 2'd1, // picked channel as grey
        DISP_MASK    = 2'd2, // white where masked, black elsewhere
        DISP_OVERLAY = 2'd3  // magenta over the camera image
    } display_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1, // one quotient bit per clock
        DIV_DONE = 2'd2  // result valid for one cycle
    } div_state_e;

    typedef struct packed {
        logic [`CHAN_W-1:0] r;
        logic [`CHAN_W-1:0] g;
        logic [`CHAN_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [`CHAN_W-1:0] y;
        logic [`CHAN_W-1:0] cr;
        logic [`CHAN_W-1:0] cb;
    } ycc_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the tracker testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_color_tracker \
    -Mdir obj_dir -o sim_tracker
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tracker > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

/* test/tb_color_tracker.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

module tb_color_tracker import tracker_pkg::*; ();

    localparam int FRAME_W     = 32;
    localparam int FRAME_H     = 16;
    localparam int NUM_TESTS   = 10;
    localparam int FIELDS      = 11;   // hex words per test line
    localparam int SEND_LIMIT  = 200;  // cycles allowed for one input handshake
    localparam int DRAIN_LIMIT = 4000; // cycles allowed for a frame to leave

    logic                 clk_pixel   = 1'b0;
    logic                 recent_reset;
    logic                 pix_valid_i;
    logic                 pix_ready_o;
    logic [15:0]          pix_data_i;
    logic [`HCOUNT_W-1:0] pix_hcount_i;
    logic [`VCOUNT_W-1:0] pix_vcount_i;
    logic                 pix_last_i;
    channel_e             channel_i;
    logic [`CHAN_W-1:0]   lower_i;
    logic [`CHAN_W-1:0]   upper_i;
    display_e             display_i;
    logic                 crosshair_i;
    logic                 out_valid_o;
    logic                 out_ready_i = 1'b0;
    rgb_t                 out_rgb_o;
    logic                 out_mask_o;
    logic                 com_valid_o;
    logic [`HCOUNT_W-1:0] com_x_o;
    logic [`VCOUNT_W-1:0] com_y_o;

    logic [15:0] test_mem [0:NUM_TESTS*FIELDS-1];
    logic [31:0] lfsr     = 32'h15cb;
    logic        aborted;           // a wait ran out or the test file is missing
    int          errors, checks, pending;
    logic        com_due;

    color_tracker i_dut (.*);

    tracker_checker i_checker (
        .clk_pixel    (clk_pixel),    .recent_reset (recent_reset),
        .pix_valid_i  (pix_valid_i),  .pix_ready_i  (pix_ready_o),
        .pix_data_i   (pix_data_i),   .pix_hcount_i (pix_hcount_i),
        .pix_vcount_i (pix_vcount_i), .pix_last_i   (pix_last_i),
        .channel_i    (channel_i),    .lower_i      (lower_i),
        .upper_i      (upper_i),      .display_i    (display_i),
        .crosshair_i  (crosshair_i),  .out_valid_i  (out_valid_o),
        .out_ready_i  (out_ready_i),  .out_rgb_i    (out_rgb_o),
        .out_mask_i   (out_mask_o),   .com_valid_i  (com_valid_o),
        .com_x_i      (com_x_o),      .com_y_i      (com_y_o),
        .errors_o     (errors),       .checks_o     (checks),
        .pending_o    (pending),      .com_due_o    (com_due)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always #4 clk_pixel = ~clk_pixel; // 8 ns period

    always @(posedge clk_pixel) begin
        lfsr        = lfsr_step(lfsr);
        out_ready_i <= lfsr[0]; // random back-pressure
    end

    task automatic send_pixel(input logic [15:0] data, input int h, input int v,
                              input logic last);
        int waited;
        waited       = 0;
        pix_valid_i  <= 1'b1;
        pix_data_i   <= data;
        pix_hcount_i <= `HCOUNT_W'(h);
        pix_vcount_i <= `VCOUNT_W'(v);
        pix_last_i   <= last;
        do begin
            @(posedge clk_pixel);
            waited++;
        end while (!pix_ready_o && waited < SEND_LIMIT);
        if (!pix_ready_o) begin
            $display("timeout: pix_ready_o stayed low for %0d cycles", SEND_LIMIT);
            aborted = 1'b1;
        end
    endtask

    // one frame, object rectangle over a flat background
    task automatic run_frame(input int base);
        int h;
        int v;
        for (v = 0; v < FRAME_H && !aborted; v++) begin
            for (h = 0; h < FRAME_W && !aborted; h++) begin
                send_pixel((h >= int'(test_mem[base+2]) && h <= int'(test_mem[base+4]) &&
                            v >= int'(test_mem[base+3]) && v <= int'(test_mem[base+5]))
                               ? test_mem[base+1] : test_mem[base],
                           h, v, (h == FRAME_W - 1) && (v == FRAME_H - 1));
            end
        end
        pix_valid_i <= 1'b0;
        pix_last_i  <= 1'b0;
    endtask

    // all beats out and the centre pulse seen, if one is owed
    task automatic wait_drain();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_pixel);
            waited++;
        end while ((pending != 0 || com_due) && waited < DRAIN_LIMIT);
        if (pending != 0 || com_due) begin
            $display("timeout: %0d beats or the centre of mass still missing after %0d cycles",
                     pending, DRAIN_LIMIT);
            aborted = 1'b1;
        end
    endtask

    initial begin
        int t;
        int rep;
        int base;
        int err_before;
        int tests_run;
        aborted      = 1'b0;
        tests_run    = 0;
        recent_reset = 1'b1;
        pix_valid_i  = 1'b0;
        pix_data_i   = '0;
        pix_hcount_i = '0;
        pix_vcount_i = '0;
        pix_last_i   = 1'b0;
        channel_i    = CH_Y;
        lower_i      = '0;
        upper_i      = '0;
        display_i    = DISP_CAMERA;
        crosshair_i  = 1'b0;
        test_mem[NUM_TESTS*FIELDS-1] = 16'hffff; // sentinel, real value is 0 or 1
        $readmemh("test/tracker_tests.txt", test_mem);
        if (test_mem[NUM_TESTS*FIELDS-1] == 16'hffff) begin
            $display("test file test/tracker_tests.txt is missing or too short");
            aborted = 1'b1;
        end
        repeat (4) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        for (t = 0; t < NUM_TESTS && !aborted; t++) begin
            base        = t * FIELDS;
            err_before  = errors;
            channel_i   <= channel_e'(test_mem[base+6][1:0]);
            lower_i     <= test_mem[base+7][7:0];
            upper_i     <= test_mem[base+8][7:0];
            display_i   <= display_e'(test_mem[base+9][1:0]);
            crosshair_i <= test_mem[base+10][0];
            for (rep = 0; rep < 2 && !aborted; rep++) begin // second pass sees its own centre
                run_frame(base);
                if (!aborted) wait_drain();
            end
            if (!aborted) begin
                tests_run++;
                $display("test %0d finished with %0d errors", t + 1, errors - err_before);
            end
        end
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (aborted || errors != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

/* test/tracker_checker.sv */
`timescale 1ns/1ps
`include "tracker_consts.svh"

// scoreboard that models each accepted input pixel and compares the output stream
module tracker_checker import tracker_pkg::*; (
    input  logic                 clk_pixel,
    input  logic                 recent_reset,
    input  logic                 pix_valid_i,
    input  logic                 pix_ready_i,
    input  logic [15:0]          pix_data_i,
    input  logic [`HCOUNT_W-1:0] pix_hcount_i,
    input  logic [`VCOUNT_W-1:0] pix_vcount_i,
    input  logic                 pix_last_i,
    input  channel_e             channel_i,
    input  logic [`CHAN_W-1:0]   lower_i,
    input  logic [`CHAN_W-1:0]   upper_i,
    input  display_e             display_i,
    input  logic                 crosshair_i,
    input  logic                 out_valid_i,
    input  logic                 out_ready_i,
    input  rgb_t                 out_rgb_i,
    input  logic                 out_mask_i,
    input  logic                 com_valid_i,
    input  logic [`HCOUNT_W-1:0] com_x_i,
    input  logic [`VCOUNT_W-1:0] com_y_i,
    output int                   errors_o,
    output int                   checks_o,
    output int                   pending_o,  // beats still owed by the DUT
    output logic                 com_due_o   // centre owed for the last frame
);

    logic [24:0] want_q[$];          // {rgb, mask} in input order
    logic        was_reset = 1'b0;
    logic        com_due   = 1'b0;
    int          errors    = 0;
    int          checks    = 0;
    int          sum_x, sum_y, cnt;  // running totals of the frame on the input
    int          held_x, held_y;     // centre the crosshair is drawn at
    int          want_x, want_y;

    task automatic check_val(input string name, input logic [31:0] want,
                             input logic [31:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h got %0h", name, want, got);
        end
    endtask

    // bt.601 byte from an rgb565 word
    function automatic logic [7:0] conv(input logic [15:0] d, input int kr, input int kg,
                                        input int kb, input int ofs);
        int r;
        int g;
        int b;
        int acc;
        r   = int'({d[15:11], 3'b000}); // low bits zero filled
        g   = int'({d[10:5], 2'b00});
        b   = int'({d[4:0], 3'b000});
        acc = ((kr * r + kg * g + kb * b + 128) >>> 8) + ofs; // floor shift
        return acc[7:0];
    endfunction

    function automatic logic [24:0] model_pixel(input logic [15:0] d, input int h, input int v);
        logic [23:0] cam;
        logic [23:0] pix;
        logic [7:0]  pick;
        logic        m;
        cam = {d[15:11], 3'b000, d[10:5], 2'b00, d[4:0], 3'b000};
        case (channel_i)
            CH_CR:   pick = conv(d, 112, -94, -18, 128);
            CH_CB:   pick = conv(d, -38, -74, 112, 128);
            default: pick = conv(d, 66, 129, 25, 16);
        endcase
        m = (pick >= lower_i) && (pick <= upper_i); // inclusive window
        case (display_i)
            DISP_CHANNEL: pix = {3{pick}};
            DISP_MASK:    pix = m ? 24'hffffff : 24'h000000;
            DISP_OVERLAY: pix = m ? 24'hff00ff : cam;
            default:      pix = cam;
        endcase
        if (crosshair_i && (h == held_x || v == held_y)) begin
            pix = 24'hffffff; // crosshair beats every mode
        end
        return {pix, m};
    endfunction

    always @(posedge clk_pixel) begin
        logic [24:0] want;
        int          h;
        int          v;
        if (recent_reset) begin
            want_q.delete();
            sum_x   = 0;
            sum_y   = 0;
            cnt     = 0;
            held_x  = 0;
            held_y  = 0;
            com_due = 1'b0;
        end else begin
            if (was_reset) begin // first edge after reset
                check_val("out_valid_o", 0, 32'(out_valid_i));
                check_val("com_valid_o", 0, 32'(com_valid_i));
                check_val("com_x_o", 0, 32'(com_x_i));
                check_val("com_y_o", 0, 32'(com_y_i));
                check_val("pix_ready_o", 1, 32'(pix_ready_i));
            end
            if (out_valid_i && out_ready_i) begin
                if (want_q.size() == 0) begin
                    errors++;
                    $display("output beat arrived with no input pixel waiting for it");
                end else begin
                    want = want_q.pop_front();
                    check_val("out_rgb_o", 32'(want[24:1]), 32'(out_rgb_i));
                    check_val("out_mask_o", 32'(want[0]), 32'(out_mask_i));
                end
            end
            if (com_valid_i) begin
                if (!com_due) begin
                    errors++;
                    $display("com_valid_o pulsed although no frame with masked pixels ended");
                end else begin
                    check_val("com_x_o", want_x, 32'(com_x_i));
                    check_val("com_y_o", want_y, 32'(com_y_i));
                    com_due = 1'b0;
                end
            end
            if (pix_valid_i && pix_ready_i) begin
                h    = int'(pix_hcount_i);
                v    = int'(pix_vcount_i);
                want = model_pixel(pix_data_i, h, v);
                want_q.push_back(want);
                if (want[0]) begin
                    sum_x += h;
                    sum_y += v;
                    cnt++;
                end
                if (pix_last_i) begin
                    if (cnt != 0) begin // empty frame keeps the old centre
                        want_x  = sum_x / cnt;
                        want_y  = sum_y / cnt;
                        held_x  = want_x;
                        held_y  = want_y;
                        com_due = 1'b1;
                    end
                    sum_x = 0;
                    sum_y = 0;
                    cnt   = 0;
                end
            end
        end
        was_reset <= recent_reset;
        errors_o  <= errors;
        checks_o  <= checks;
        pending_o <= want_q.size();
        com_due_o <= com_due;
    end

endmodule

/* test/tracker_tests.txt */
// bg obj x0 y0 x1 y1 chan lower upper disp cross, all hex, colours in rgb565
// chan 0 y 1 cr 2 cb, disp 0 camera 1 channel 2 mask 3 overlay, rectangle inclusive
8410 f800 04 02 0b 07 1 c8 ff 0 0
8410 001f 10 03 17 0a 2 c8 ff 1 0
0000 ffff 00 00 1f 0f 0 c8 ff 2 0
8410 07e0 14 08 1c 0e 1 00 3f 3 0
8410 f800 04 02 0b 07 1 c8 ff 3 1
8410 8410 00 00 00 00 1 c8 ff 0 1
0000 ffe0 1a 0c 1f 0f 2 00 30 1 1
8410 f81f 00 00 03 03 0 40 70 2 0
8410 ffff 08 04 08 04 0 c8 ff 3 1
f800 0000 0a 05 0d 08 1 00 90 2 1
